//--- src/predecode_settings.svh
// fixed bundle geometry of 15 parcels with end bits from bit 240 and no wide mode
`ifndef PREDECODE_SETTINGS_SVH
`define PREDECODE_SETTINGS_SVH

// bundle geometry
`define PARCEL_BITS 16
`define BUNDLE_PARCELS 15
`define BUNDLE_BITS 256
`define END_LSB 240

// raw bits kept per instruction slot
`define INSTR_WINDOW_BITS 80

// output slot counts
`define MAX_INSTR 12
`define MAX_JUMPS 4

// wide enough for a count of all 15 parcels
`define RANK_BITS 5

`endif

//--- src/predecodePkg.sv
// slot layouts are fixed and jump slots keep only the low four class flags
`include "predecode_settings.svh"

package predecodePkg;

  // first two parcels of an instruction
  localparam int SHORT_WINDOW_BITS = 2 * `PARCEL_BITS;

  typedef logic [3:0] lengthCodeT; // bit j set while parcel k+j is not the last one
  typedef logic [3:0] offsetT;     // parcel index
  typedef logic [`RANK_BITS-1:0] rankT;

  // flags may overlap, jump sits in bit 0
  typedef struct packed {
    logic sys;
    logic fpu;
    logic store;
    logic load;
    logic mul;
    logic shift;
    logic alu;
    logic jump;
  } classT;

  typedef struct packed {
    logic [`INSTR_WINDOW_BITS-1:0] raw;
    lengthCodeT                    lengthCode;
    offsetT                        offset;
    classT                         cls;
  } instrSlotT;

  typedef struct packed {
    logic [SHORT_WINDOW_BITS-1:0] raw;
    lengthCodeT                   lengthCode;
    offsetT                       offset;
    logic [3:0]                   cls; // jump, alu, shift, mul
  } jumpSlotT;

endpackage

//--- src/reqAckControl.sv
// one bundle in flight and inputs must stay stable while req is high; ack follows two edges later
`timescale 1ns/1ns
`include "predecode_settings.svh"

module reqAckControl
  import predecodePkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req,
  input  logic [`BUNDLE_BITS-1:0] bundle,
  input  offsetT                  startOff,
  output logic [`BUNDLE_BITS-1:0] bundleReg,
  output offsetT                  startOffReg,
  output logic                    loadResult,
  output logic                    ack
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } stateT;

  stateT state;
  stateT stateNext;
  logic  capture;

  assign capture = (state == IDLE) && req;

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (capture) begin
          stateNext = BUSY;
        end
      end
      BUSY: begin
        stateNext = DONE; // scan settles within this cycle
      end
      DONE: begin
        if (!req) begin
          stateNext = IDLE;
        end
      end
      default: begin
        stateNext = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  // captured on entry to busy
  always_ff @(posedge clk) begin
    if (capture) begin
      bundleReg   <= bundle;
      startOffReg <= startOff;
    end
  end

  assign loadResult = (state == BUSY); // single cycle pulse
  assign ack        = (state == DONE); // held until req drops

endmodule

//--- src/boundaryScan.sv
// end bits past parcel 14 read as zero so trailing length codes show not-end bits
`timescale 1ns/1ns
`include "predecode_settings.svh"

module boundaryScan
  import predecodePkg::*;
(
  input  logic [`BUNDLE_BITS-1:0]    bundleReg,
  input  offsetT                     startOffReg,
  input  classT                      cls [`BUNDLE_PARCELS],
  output lengthCodeT                 lengthCode [`BUNDLE_PARCELS],
  output logic [`BUNDLE_PARCELS-1:0] isInstr,
  output logic [`BUNDLE_PARCELS-1:0] isJump,
  output rankT                       instrRank [`BUNDLE_PARCELS],
  output rankT                       jumpRank [`BUNDLE_PARCELS]
);

  localparam int N = `BUNDLE_PARCELS;

  logic [N-1:0] endBit;
  logic [N+2:0] endPad;
  logic [N-1:0] startMask; // raw starts before the offset cut
  logic [N-1:0] offMask;

  assign endBit    = bundleReg[`END_LSB +: N];
  assign endPad    = {3'b000, endBit};
  assign startMask = {endBit[N-2:0], 1'b1}; // parcel 0 always starts

  always_comb begin
    for (int k = 0; k < N; k++) begin
      offMask[k]    = (k >= int'(startOffReg));
      lengthCode[k] = ~endPad[k +: 4];
    end
  end

  assign isInstr = startMask & offMask;

  always_comb begin
    for (int k = 0; k < N; k++) begin
      isJump[k] = isInstr[k] & cls[k].jump;
    end
  end

  // inclusive running counts up to each parcel
  always_comb begin : rankCount
    rankT instrRun;
    rankT jumpRun;
    instrRun = '0;
    jumpRun  = '0;
    for (int k = 0; k < N; k++) begin
      instrRun     = instrRun + rankT'(isInstr[k]);
      jumpRun      = jumpRun + rankT'(isJump[k]);
      instrRank[k] = instrRun;
      jumpRank[k]  = jumpRun;
    end
  end

endmodule

//--- src/parcelClassifier.sv
// reduced opcode table on the first byte only; window bits above 7 carry no class information
`timescale 1ns/1ns

module parcelClassifier
  import predecodePkg::*;
(
  input  logic [SHORT_WINDOW_BITS-1:0] window,
  input  lengthCodeT                   lengthCode,
  output classT                        cls
);

  logic [7:0] op;
  logic [5:0] sub;
  logic       longForm;

  // long form groups
  logic lfArith;
  logic lfShift;
  logic lfMem;
  logic lfCondJump;
  logic lfJump;
  logic lfFpu;
  logic lfSys;

  // short form groups
  logic sfJump;
  logic sfAlu;
  logic sfShift;

  assign op       = window[7:0];
  assign sub      = op[5:0];
  assign longForm = lengthCode[0]; // first parcel does not end it

  assign lfArith    = longForm && (op <= 8'd39);
  assign lfShift    = longForm && (op >= 8'd40) && (op <= 8'd45);
  assign lfMem      = longForm && (op[7:5] == 3'b010); // 64..95
  assign lfCondJump = op[7:4] == 4'hA;                 // 160..175
  assign lfJump     = longForm && (lfCondJump || (op == 8'd180) || (op == 8'd181));
  assign lfFpu      = longForm && (op == 8'd240);
  assign lfSys      = longForm && (op == 8'd255);

  assign sfJump  = !longForm && (sub[5:2] == 4'b1100); // 48..51
  assign sfAlu   = !longForm && !sub[5];               // 0..31
  assign sfShift = !longForm && (sub[5:4] == 2'b10);   // 32..47

  // bit 2 splits alu from mul in the low range
  always_comb begin
    cls       = '0;
    cls.jump  = lfJump | sfJump;
    cls.alu   = (lfArith & ~op[2]) | sfAlu;
    cls.shift = lfShift | sfShift;
    cls.mul   = lfArith & op[2];
    cls.load  = lfMem & ~op[0];
    cls.store = lfMem & op[0];
    cls.fpu   = lfFpu;
    cls.sys   = lfSys;
  end

endmodule

//--- src/slotCompactor.sv
// rank must be the inclusive count of sel, so the last rank is the number of selected items
`timescale 1ns/1ns
`include "predecode_settings.svh"

module slotCompactor
  import predecodePkg::*;
#(
  parameter type payloadT = logic [7:0],
  parameter int  SLOTS    = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       loadResult,
  input  payloadT                    payload [`BUNDLE_PARCELS],
  input  logic [`BUNDLE_PARCELS-1:0] sel,
  input  rankT                       rank [`BUNDLE_PARCELS],
  output payloadT                    slot [SLOTS],
  output logic [SLOTS-1:0]           slotEn,
  output logic                       overflow
);

  payloadT slotNext [SLOTS];
  rankT    total;

  assign total = rank[`BUNDLE_PARCELS-1];

  // slot r takes the item ranked r+1, empty slots stay zero
  always_comb begin
    for (int r = 0; r < SLOTS; r++) begin
      slotNext[r] = '0;
      for (int k = 0; k < `BUNDLE_PARCELS; k++) begin
        if (sel[k] && (rank[k] == rankT'(r + 1))) begin
          slotNext[r] = payload[k];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (loadResult) begin
      slot <= slotNext;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      slotEn   <= '0;
      overflow <= 1'b0;
    end else if (loadResult) begin
      for (int r = 0; r < SLOTS; r++) begin
        slotEn[r] <= total > rankT'(r); // thermometer
      end
      overflow <= total > rankT'(SLOTS);
    end
  end

endmodule

//--- src/predecodeTop.sv
// one bundle per four-phase handshake; slots and enables hold until the next load
`timescale 1ns/1ns
`include "predecode_settings.svh"

module predecodeTop
  import predecodePkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req,
  input  logic [`BUNDLE_BITS-1:0] bundle,
  input  offsetT                  startOff,
  output logic                    ack,
  output instrSlotT               instrSlot [`MAX_INSTR],
  output logic [`MAX_INSTR-1:0]   instrEn,
  output jumpSlotT                jumpSlot [`MAX_JUMPS],
  output logic [`MAX_JUMPS-1:0]   jumpEn,
  output logic                    error,
  output logic                    jumpError
);

  localparam int N            = `BUNDLE_PARCELS;
  localparam int PARCEL_FIELD = N * `PARCEL_BITS;
  localparam int PAD_BITS     = `INSTR_WINDOW_BITS - `PARCEL_BITS;

  logic [`BUNDLE_BITS-1:0]        bundleReg;
  offsetT                         startOffReg;
  logic                           loadResult;
  logic [PARCEL_FIELD+PAD_BITS-1:0] parcels; // zeros past the last parcel
  classT                          cls [N];
  lengthCodeT                     lengthCode [N];
  logic [N-1:0]                   isInstr;
  logic [N-1:0]                   isJump;
  rankT                           instrRank [N];
  rankT                           jumpRank [N];
  instrSlotT                      instrPayload [N];
  jumpSlotT                       jumpPayload [N];

  reqAckControl i_reqAck (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .bundle      (bundle),
    .startOff    (startOff),
    .bundleReg   (bundleReg),
    .startOffReg (startOffReg),
    .loadResult  (loadResult),
    .ack         (ack)
  );

  assign parcels = {{PAD_BITS{1'b0}}, bundleReg[PARCEL_FIELD-1:0]};

  boundaryScan i_scan (
    .bundleReg   (bundleReg),
    .startOffReg (startOffReg),
    .cls         (cls),
    .lengthCode  (lengthCode),
    .isInstr     (isInstr),
    .isJump      (isJump),
    .instrRank   (instrRank),
    .jumpRank    (jumpRank)
  );

  for (genvar k = 0; k < N; k++) begin : gParcel
    parcelClassifier i_classifier (
      .window     (parcels[k*`PARCEL_BITS +: SHORT_WINDOW_BITS]),
      .lengthCode (lengthCode[k]),
      .cls        (cls[k])
    );

    assign instrPayload[k] = '{
      raw:        parcels[k*`PARCEL_BITS +: `INSTR_WINDOW_BITS],
      lengthCode: lengthCode[k],
      offset:     offsetT'(k),
      cls:        cls[k]
    };

    assign jumpPayload[k] = '{
      raw:        parcels[k*`PARCEL_BITS +: SHORT_WINDOW_BITS],
      lengthCode: lengthCode[k],
      offset:     offsetT'(k),
      cls:        cls[k][3:0]
    };
  end

  slotCompactor #(.payloadT(instrSlotT), .SLOTS(`MAX_INSTR)) instrCompactor (
    .clk        (clk),
    .reset      (reset),
    .loadResult (loadResult),
    .payload    (instrPayload),
    .sel        (isInstr),
    .rank       (instrRank),
    .slot       (instrSlot),
    .slotEn     (instrEn),
    .overflow   (error)
  );

  slotCompactor #(.payloadT(jumpSlotT), .SLOTS(`MAX_JUMPS)) jumpCompactor (
    .clk        (clk),
    .reset      (reset),
    .loadResult (loadResult),
    .payload    (jumpPayload),
    .sel        (isJump),
    .rank       (jumpRank),
    .slot       (jumpSlot),
    .slotEn     (jumpEn),
    .overflow   (jumpError)
  );

endmodule

//--- test/predecode_chk.sv
// assumes the requester keeps to the four-phase protocol; slot contents are not checked here
`timescale 1ns/1ns
`include "predecode_settings.svh"

module predecodeChk (
  input logic                  clk,
  input logic                  reset,
  input logic                  req,
  input logic                  ack,
  input logic [`MAX_INSTR-1:0] instrEn,
  input logic [`MAX_JUMPS-1:0] jumpEn,
  input logic                  error,
  input logic                  jumpError
);

  // no ack without a request seen first
  ackNeedsReq: assert property (@(posedge clk) disable iff (reset) (!ack && !req) |=> !ack)
    else $error("ack rose without a request");

  ackWaitsForReq: assert property (@(posedge clk) disable iff (reset) $fell(ack) |-> $past(!req))
    else $error("ack dropped while req was still high");

  // enables fill from slot 0 upward
  instrEnThermo: assert property (@(posedge clk) disable iff (reset)
    ((instrEn >> 1) & ~instrEn) == '0)
    else $error("instrEn is not a thermometer mask");

  jumpEnThermo: assert property (@(posedge clk) disable iff (reset)
    ((jumpEn >> 1) & ~jumpEn) == '0)
    else $error("jumpEn is not a thermometer mask");

  resultsHold: assert property (@(posedge clk) disable iff (reset)
    (ack && $past(ack)) |-> $stable({instrEn, jumpEn, error, jumpError}))
    else $error("results changed while ack was high");

endmodule

bind predecodeTop predecodeChk i_chk (
  .clk        (clk),
  .reset      (reset),
  .req        (req),
  .ack        (ack),
  .instrEn    (instrEn),
  .jumpEn     (jumpEn),
  .error      (error),
  .jumpError  (jumpError)
);

//--- test/predecodeTb.sv
// one bundle per handshake; the reference model knows only the reduced opcode table
`timescale 1ns/1ns
`include "predecode_settings.svh"

module predecodeTb
  import predecodePkg::*;
();

  localparam int TEST_COUNT      = 25; // handshakes plus the reset check
  localparam int WATCHDOG_CYCLES = TEST_COUNT * 40 + 100;

  logic                    clk;
  logic                    reset;
  logic                    req;
  logic [`BUNDLE_BITS-1:0] bundle;
  offsetT                  startOff;
  logic                    ack;
  instrSlotT               instrSlot [`MAX_INSTR];
  logic [`MAX_INSTR-1:0]   instrEn;
  jumpSlotT                jumpSlot [`MAX_JUMPS];
  logic [`MAX_JUMPS-1:0]   jumpEn;
  logic                    error;
  logic                    jumpError;

  predecodeTop i_dut (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .bundle    (bundle),
    .startOff  (startOff),
    .ack       (ack),
    .instrSlot (instrSlot),
    .instrEn   (instrEn),
    .jumpSlot  (jumpSlot),
    .jumpEn    (jumpEn),
    .error     (error),
    .jumpError (jumpError)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

  task automatic checkEq(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // reduced class table on the first byte
  function automatic classT classOf(input logic [7:0] op, input logic longForm);
    classT      c;
    logic [5:0] sub;
    c   = '0;
    sub = op[5:0];
    if (longForm) begin
      if (op < 8'd40) begin
        c.mul = op[2];
        c.alu = ~op[2];
      end else if (op inside {[8'd40:8'd45]}) begin
        c.shift = 1'b1;
      end else if (op inside {[8'd64:8'd95]}) begin
        c.store = op[0];
        c.load  = ~op[0];
      end else if (op inside {[8'd160:8'd175], 8'd180, 8'd181}) begin
        c.jump = 1'b1;
      end else begin
        c.fpu = (op == 8'd240);
        c.sys = (op == 8'd255);
      end
    end else if (sub inside {[6'd48:6'd51]}) begin
      c.jump = 1'b1;
    end else begin
      c.alu   = (sub < 6'd32);
      c.shift = sub inside {[6'd32:6'd47]};
    end
    return c;
  endfunction

  task automatic expectResults(input logic [`BUNDLE_BITS-1:0] b, input offsetT off);
    logic [319:0]          padded;
    logic [17:0]           ends;
    logic [14:0]           starts;
    instrSlotT             expInstr [`MAX_INSTR];
    jumpSlotT              expJump [`MAX_JUMPS];
    instrSlotT             item;
    jumpSlotT              jItem;
    logic [`MAX_INSTR-1:0] expEn;
    logic [`MAX_JUMPS-1:0] expJumpEn;
    int                    nInstr;
    int                    nJump;
    padded = {80'b0, b[239:0]}; // zeros past parcel 14
    ends   = {3'b000, b[254:240]};
    starts = {b[253:240], 1'b1};
    nInstr = 0;
    nJump  = 0;
    for (int r = 0; r < `MAX_INSTR; r++) begin
      expInstr[r] = '0;
    end
    for (int r = 0; r < `MAX_JUMPS; r++) begin
      expJump[r] = '0;
    end
    for (int k = 0; k < `BUNDLE_PARCELS; k++) begin
      if (starts[k] && k >= int'(off)) begin
        item.raw        = padded[k*16 +: 80];
        item.lengthCode = ~ends[k +: 4];
        item.offset     = offsetT'(k);
        item.cls        = classOf(padded[k*16 +: 8], ~ends[k]);
        if (nInstr < `MAX_INSTR) begin
          expInstr[nInstr] = item;
        end
        nInstr++;
        if (item.cls.jump) begin
          jItem.raw        = padded[k*16 +: 32];
          jItem.lengthCode = item.lengthCode;
          jItem.offset     = item.offset;
          jItem.cls        = item.cls[3:0];
          if (nJump < `MAX_JUMPS) begin
            expJump[nJump] = jItem;
          end
          nJump++;
        end
      end
    end
    for (int r = 0; r < `MAX_INSTR; r++) begin
      expEn[r] = r < nInstr;
      checkEq(128'(instrSlot[r]), 128'(expInstr[r]), $sformatf("instruction slot %0d", r));
    end
    for (int r = 0; r < `MAX_JUMPS; r++) begin
      expJumpEn[r] = r < nJump;
      checkEq(128'(jumpSlot[r]), 128'(expJump[r]), $sformatf("jump slot %0d", r));
    end
    checkEq(128'(instrEn), 128'(expEn), "instrEn");
    checkEq(128'(jumpEn), 128'(expJumpEn), "jumpEn");
    checkEq(128'(error), 128'(nInstr > `MAX_INSTR), "error");
    checkEq(128'(jumpError), 128'(nJump > `MAX_JUMPS), "jumpError");
  endtask

  // called 1 ns after a rising edge, returns at the same phase
  task automatic runHandshake(input logic [`BUNDLE_BITS-1:0] b, input offsetT off);
    int cycles;
    bundle   = b;
    startOff = off;
    req      = 1'b1;
    cycles   = 0;
    while (!ack && cycles < 10) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!ack) begin
      $display("ack never rose after req at %0t ns", $time);
      $display("TEST RESULT: FAIL");
      $fatal(1, "handshake timeout");
    end
    checkEq(128'(cycles), 128'(2), "cycles from req to ack");
    expectResults(b, off);
    @(posedge clk); // req stays up one more cycle
    #1;
    checkEq(128'(ack), 128'(1), "ack held while req is high");
    expectResults(b, off); // results hold while ack is high
    req    = 1'b0;
    cycles = 0;
    while (ack && cycles < 10) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    checkEq(128'(cycles), 128'(1), "cycles from req low to ack low");
  endtask

  function automatic logic [`BUNDLE_BITS-1:0] randomBundle();
    logic [`BUNDLE_BITS-1:0] b;
    for (int w = 0; w < 8; w++) begin
      b[w*32 +: 32] = $urandom;
    end
    return b;
  endfunction

  // one instruction of len parcels at pos, opcode in the low byte
  function automatic void placeInstr(inout logic [`BUNDLE_BITS-1:0] b, inout int pos,
                                     input int len, input logic [7:0] op);
    for (int j = 0; j < len; j++) begin
      b[(pos+j)*16 +: 16] = 16'($urandom);
    end
    b[pos*16 +: 8]            = op;
    b[`END_LSB + pos + len - 1] = 1'b1;
    pos = pos + len;
  endfunction

  function automatic logic [`BUNDLE_BITS-1:0] mixedBundle();
    logic [`BUNDLE_BITS-1:0] b;
    int                      pos;
    b   = '0;
    pos = 0;
    placeInstr(b, pos, 2, 8'd3);   // alu
    placeInstr(b, pos, 1, 8'hca);  // short alu, sub 10
    placeInstr(b, pos, 3, 8'd42);  // shift
    placeInstr(b, pos, 2, 8'd65);  // store
    placeInstr(b, pos, 1, 8'h71);  // short jump
    placeInstr(b, pos, 2, 8'd170); // jump
    placeInstr(b, pos, 1, 8'h28);  // short shift
    placeInstr(b, pos, 2, 8'd240); // fpu
    placeInstr(b, pos, 1, 8'h3f);  // no class
    return b;
  endfunction

  task automatic testResetState();
    repeat (2) @(posedge clk);
    #1;
    checkEq(128'(ack), 128'(0), "ack after reset");
    checkEq(128'(instrEn), 128'(0), "instrEn after reset");
    checkEq(128'(jumpEn), 128'(0), "jumpEn after reset");
    checkEq(128'(error), 128'(0), "error after reset");
    checkEq(128'(jumpError), 128'(0), "jumpError after reset");
  endtask

  task automatic testAllEnds();
    logic [`BUNDLE_BITS-1:0] b;
    b          = randomBundle();
    b[255:240] = 16'h7fff;
    runHandshake(b, 4'd0);
    checkEq(128'(instrEn), 128'(12'hfff), "instrEn with all ends");
    checkEq(128'(instrSlot[11].offset), 128'(11), "offset of slot 11");
    checkEq(128'(error), 128'(1), "error with all ends");
  endtask

  task automatic testMixedForms();
    runHandshake(mixedBundle(), 4'd0);
    checkEq(128'(instrSlot[2].lengthCode), 128'(4'b1011), "three parcel length code");
    checkEq(128'(instrSlot[2].cls.shift), 128'(1), "shift class");
    checkEq(128'(instrSlot[3].cls.store), 128'(1), "store class");
    checkEq(128'(error), 128'(0), "error with mixed forms");
  endtask

  task automatic testStartOffset();
    runHandshake(mixedBundle(), 4'd5);
    checkEq(128'(instrSlot[0].offset), 128'(6), "first offset at or past 5");
    checkEq(128'(instrEn), 128'(12'h03f), "instrEn with offset");
  endtask

  task automatic testSixJumps();
    logic [`BUNDLE_BITS-1:0] b;
    int                      pos;
    b   = '0;
    pos = 0;
    placeInstr(b, pos, 1, 8'h30);
    placeInstr(b, pos, 2, 8'd0);
    placeInstr(b, pos, 1, 8'h33);
    placeInstr(b, pos, 2, 8'd180);
    placeInstr(b, pos, 3, 8'd165);
    placeInstr(b, pos, 1, 8'h05);
    placeInstr(b, pos, 1, 8'h32);
    placeInstr(b, pos, 2, 8'd181);
    placeInstr(b, pos, 2, 8'd1);
    runHandshake(b, 4'd0);
    checkEq(128'(jumpEn), 128'(4'hf), "jumpEn with six jumps");
    checkEq(128'(jumpSlot[3].offset), 128'(6), "fourth jump offset");
    checkEq(128'(jumpError), 128'(1), "jumpError with six jumps");
  endtask

  task automatic testRandomBundles();
    repeat (20) begin
      runHandshake(randomBundle(), offsetT'($urandom % 16));
    end
  endtask

  initial begin
    reset    = 1'b1;
    req      = 1'b0;
    bundle   = '0;
    startOff = '0;
    void'($urandom(32'h3cb));
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    testResetState();
    testAllEnds();
    testMixedForms();
    testStartOffset();
    testSixJumps();
    testRandomBundles();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- list.f
+incdir+src
src/predecodePkg.sv
src/reqAckControl.sv
src/boundaryScan.sv
src/parcelClassifier.sv
src/slotCompactor.sv
src/predecodeTop.sv
test/predecode_chk.sv
test/predecodeTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds predecodeTb with Verilator and runs it; exit status follows the simulation
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module predecodeTb \
  -Mdir obj_dir -o predecodeSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/predecodeSim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

echo "simulation finished cleanly"
exit 0
